//--- compile.f
verilog/scaler_pkg.sv
verilog/coord_gen.sv
verilog/tag_delay.sv
verilog/bilinear_blend.sv
verilog/image_scaler_top.sv
sim/scaler_checker.sv
sim/scaler_tb.sv

//--- sim/scaler_checker.sv
`timescale 1ns/1ps

module scaler_checker
  import scaler_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     start,
  input src_req_t src_req,
  input dst_wr_t  dst_wr,
  input logic     done
);

  int        fail_cnt = 0;
  dst_addr_t last_addr;
  logic      idle;

  // previous write address, and idle between done and the next start
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      last_addr <= '0;
      idle      <= 1'b1;
    end
    else
    begin
      if (dst_wr.valid)
        last_addr <= dst_wr.addr;
      if (start)
        idle <= 1'b0;
      else if (done)
        idle <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !(src_req.valid || dst_wr.valid || done))
  else
  begin
    $error("output active while reset is held");
    fail_cnt++;
  end

  a_done_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> dst_wr.valid)
  else
  begin
    $error("done without a destination write");
    fail_cnt++;
  end

  a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
  else
  begin
    $error("done held longer than one cycle");
    fail_cnt++;
  end

  // a new frame starts over at address zero
  a_addr_order: assert property (@(posedge clk) disable iff (!rst_n)
    dst_wr.valid |-> (dst_wr.addr == '0 || dst_wr.addr == last_addr + dst_addr_t'(1)))
  else
  begin
    $error("destination write address out of order");
    fail_cnt++;
  end

  a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    idle |-> !src_req.valid)
  else
  begin
    $error("source request while the scaler is idle");
    fail_cnt++;
  end

endmodule

bind image_scaler_top scaler_checker u_checker (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .src_req (src_req),
  .dst_wr  (dst_wr),
  .done    (done)
);

//--- sim/scaler_tb.sv
`timescale 1ns/1ps

module scaler_tb
  import scaler_pkg::*;
();

  localparam int    src_w      = 16;
  localparam int    src_h      = 12;
  localparam int    dst_w      = 13;
  localparam int    dst_h      = 10;
  localparam step_t step_x     = 13'd5041;
  localparam step_t step_y     = 13'd4915;
  localparam int    mem_lat    = 1;
  localparam int    npix       = dst_w * dst_h;
  localparam int    wait_limit = 100;

  logic        clk;
  logic        rst_n;
  logic        start;
  src_req_t    src_req;
  dst_wr_t     dst_wr;
  logic        done;
  pixel_t      src_mem [src_w*src_h];
  pixel_t      rd_a [mem_lat] = '{default: 8'h00};
  pixel_t      rd_b [mem_lat] = '{default: 8'h00};
  logic [31:0] lfsr = 32'h7c21;

  image_scaler_top #(
    .src_w   (src_w),
    .src_h   (src_h),
    .dst_w   (dst_w),
    .dst_h   (dst_h),
    .step_x  (step_x),
    .step_y  (step_y),
    .mem_lat (mem_lat)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .src_data_a (rd_a[mem_lat-1]),
    .src_data_b (rd_b[mem_lat-1]),
    .src_req    (src_req),
    .dst_wr     (dst_wr),
    .done       (done)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // source memory returns data mem_lat cycles after each request
  always @(posedge clk)
  begin
    rd_a[0] <= src_req.valid ? src_mem[src_req.addr_a] : 8'h00;
    rd_b[0] <= src_req.valid ? src_mem[src_req.addr_b] : 8'h00;
    for (int i = 1; i < mem_lat; i++)
    begin
      rd_a[i] <= rd_a[i-1];
      rd_b[i] <= rd_b[i-1];
    end
  end

  always @(negedge clk)
  begin
    if (DUT.u_checker.fail_cnt != 0)
      stop_on_error("a protocol assertion in the checker failed");
  end

  // one Galois step per output bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic src_req_t expected_req(input int pix, input bit ph);
    int       ix;
    int       iy;
    src_req_t r;
    ix       = ((pix % dst_w + 1) * int'(step_x)) >> frac_bits;
    iy       = ((pix / dst_w + 1) * int'(step_y)) >> frac_bits;
    r.valid  = 1'b1;
    r.addr_a = src_addr_t'((iy - 1) * src_w + ix - 1 + int'(ph));
    r.addr_b = src_addr_t'(iy * src_w + ix - 1 + int'(ph));
    return r;
  endfunction

  // top byte of the Q24 bilinear sum over the four neighbours
  function automatic dst_wr_t expected_wr(input int pix);
    int      sx;
    int      sy;
    int      fx;
    int      fy;
    int      up;
    int      lo;
    longint  sum;
    dst_wr_t w;
    sx  = (pix % dst_w + 1) * int'(step_x);
    sy  = (pix / dst_w + 1) * int'(step_y);
    fx  = sx & (int'(one_q) - 1);
    fy  = sy & (int'(one_q) - 1);
    up  = ((sy >> frac_bits) - 1) * src_w + (sx >> frac_bits) - 1;
    lo  = up + src_w;
    sum = longint'(src_mem[up]) * (int'(one_q) - fx) * (int'(one_q) - fy)
        + longint'(src_mem[up+1]) * fx * (int'(one_q) - fy)
        + longint'(src_mem[lo]) * (int'(one_q) - fx) * fy
        + longint'(src_mem[lo+1]) * fx * fy;
    w.valid = 1'b1;
    w.addr  = dst_addr_t'(pix);
    w.data  = pixel_t'(sum >> 24);
    return w;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_req(input src_req_t got, input src_req_t exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH src_req got %h/%h/%h expected %h/%h/%h",
        got.valid, got.addr_a, got.addr_b, exp.valid, exp.addr_a, exp.addr_b));
  endtask

  task automatic check_wr(input dst_wr_t got, input dst_wr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH dst_wr got %h/%h/%h expected %h/%h/%h",
        got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic fill_random();
    pixel_t px;
    for (int a = 0; a < src_w * src_h; a++)
    begin
      px = '0;
      for (int b = 0; b < 8; b++)
      begin
        px   = {px[6:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
      end
      src_mem[a] = px;
    end
  endtask

  task automatic fill_const(input pixel_t v);
    for (int a = 0; a < src_w * src_h; a++)
      src_mem[a] = v;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > wait_limit)
        stop_on_error("timeout while waiting for a source read request");
    end while (!src_req.valid);
  endtask

  task automatic wait_write();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > wait_limit)
        stop_on_error("timeout while waiting for a destination write");
    end while (!dst_wr.valid);
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > wait_limit)
        stop_on_error("timeout while waiting for the end of the frame");
    end while (!done);
  endtask

  // writes of an aborted frame may still drain after a restart
  task automatic collect_frame(input bit restarted);
    int idx;
    idx = 0;
    while (idx < npix)
    begin
      wait_write();
      if (!(restarted && idx == 0 && dst_wr.addr != '0))
      begin
        check_wr(dst_wr, expected_wr(idx));
        check_bit("done", done, idx == npix - 1);
        idx++;
      end
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      check_bit("src_req.valid", src_req.valid, 1'b0);
      check_bit("dst_wr.valid", dst_wr.valid, 1'b0);
      check_bit("done", done, 1'b0);
    end
  endtask

  task automatic request_order();
    fill_random();
    pulse_start();
    wait_req();
    check_req(src_req, expected_req(0, 1'b0));
    for (int k = 1; k < 2 * npix; k++)
    begin
      @(negedge clk);
      check_req(src_req, expected_req(k / 2, k % 2 == 1));
    end
    wait_done();
  endtask

  task automatic full_frame();
    fill_random();
    pulse_start();
    collect_frame(1'b0);
  endtask

  task automatic frame_end();
    pulse_start();
    collect_frame(1'b0);
    expect_quiet(50);
  endtask

  task automatic constant_image();
    fill_const(8'd200);
    pulse_start();
    collect_frame(1'b0);
  endtask

  task automatic restart_mid_frame();
    fill_random();
    pulse_start();
    repeat (5) wait_write();
    pulse_start();
    collect_frame(1'b1);
    expect_quiet(10);
  endtask

  initial
  begin
    rst_n = 1'b1;
    start = 1'b0;
    fill_const(8'h00);
    // clean falling edge before the first clock
    #2 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    expect_quiet(50);
    request_order();
    full_frame();
    frame_end();
    constant_image();
    restart_mid_frame();
    if (DUT.u_checker.fail_cnt == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
      stop_on_error("a protocol assertion in the checker failed");
  end

endmodule

//--- verilog/bilinear_blend.sv
`timescale 1ns/1ps

module bilinear_blend
  import scaler_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  blend_tag_t tag,
  input  logic       tag_valid,
  input  pixel_t     src_data_a,
  input  pixel_t     src_data_b,
  output dst_wr_t    dst_wr,
  output logic       done
);

  // left column from the phase 0 beat
  pixel_t p00;
  pixel_t p01;

  logic [12:0] wx0;
  logic [12:0] wx1;
  logic [12:0] wy0;
  logic [12:0] wy1;
  logic [25:0] w00;
  logic [25:0] w01;
  logic [25:0] w10;
  logic [25:0] w11;
  logic [31:0] prod_n [4];
  logic [31:0] prod_q [4];
  logic [31:0] sum;

  logic      s1_vld;
  logic      s1_last;
  dst_addr_t s1_addr;
  logic      wr_vld_q;
  dst_addr_t wr_addr_q;
  pixel_t    wr_data_q;

  assign wx1 = {1'b0, tag.fx};
  assign wy1 = {1'b0, tag.fy};
  assign wx0 = one_q - wx1;
  assign wy0 = one_q - wy1;

  // weights sum to one_q squared
  assign w00 = wx0 * wy0;
  assign w10 = wx1 * wy0;
  assign w01 = wx0 * wy1;
  assign w11 = wx1 * wy1;

  assign prod_n[0] = p00 * w00;
  assign prod_n[1] = src_data_a * w10;
  assign prod_n[2] = p01 * w01;
  assign prod_n[3] = src_data_b * w11;

  always_ff @(posedge clk)
  begin
    if (tag_valid && !tag.phase)
    begin
      p00 <= src_data_a;
      p01 <= src_data_b;
    end
  end

  // stage 1: weights and products on the right column beat
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      s1_vld <= 1'b0;
    else
      s1_vld <= tag_valid && tag.phase;
  end

  always_ff @(posedge clk)
  begin
    if (tag_valid && tag.phase)
    begin
      prod_q  <= prod_n;
      s1_addr <= tag.dst_addr;
      s1_last <= tag.last;
    end
  end

  assign sum = prod_q[0] + prod_q[1] + prod_q[2] + prod_q[3];

  // stage 2: sum and keep the top byte
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_vld_q <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      wr_vld_q <= s1_vld;
      done     <= s1_vld && s1_last;
    end
  end

  always_ff @(posedge clk)
  begin
    if (s1_vld)
    begin
      wr_addr_q <= s1_addr;
      wr_data_q <= sum[31:24];
    end
  end

  assign dst_wr = '{valid: wr_vld_q, addr: wr_addr_q, data: wr_data_q};

endmodule

//--- verilog/coord_gen.sv
`timescale 1ns/1ps

module coord_gen
  import scaler_pkg::*;
#(
  parameter int    src_w  = 640,
  parameter int    dst_w  = 533,
  parameter int    dst_h  = 400,
  parameter step_t step_x = 13'd4918,
  parameter step_t step_y = 13'd4915
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  output src_req_t   src_req,
  output blend_tag_t tag,
  output logic       tag_valid
);

  logic      busy;
  logic      phase;
  coord_t    dx;
  coord_t    dy;
  coord_t    dx_n;
  coord_t    dy_n;
  dst_addr_t dst_cnt;
  coord_q_u  sx_q;
  coord_q_u  sy_q;

  logic        at_row_end;
  logic        at_frame_end;
  logic        advance;
  logic [10:0] ix;
  logic [10:0] iy;
  src_addr_t   row_a;
  src_addr_t   row_b;
  src_addr_t   col;

  // shift-and-add over the set bits of src_w
  function automatic src_addr_t times_src_w(input logic [10:0] row);
    src_addr_t acc;
    acc = '0;
    for (int b = 0; b < $bits(src_addr_t); b++)
    begin
      if (src_w[b])
        acc = acc + (src_addr_t'(row) << b);
    end
    return acc;
  endfunction

  assign at_row_end   = (dx == coord_t'(dst_w));
  assign at_frame_end = at_row_end && (dy == coord_t'(dst_h));
  assign advance      = busy && phase;

  // next destination coordinate, 1-based
  always_comb
  begin
    dx_n = dx;
    dy_n = dy;
    if (start)
    begin
      dx_n = coord_t'(1);
      dy_n = coord_t'(1);
    end
    else if (advance)
    begin
      if (at_row_end)
      begin
        dx_n = coord_t'(1);
        dy_n = dy + coord_t'(1);
      end
      else
        dx_n = dx + coord_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      phase   <= 1'b0;
      dx      <= '0;
      dy      <= '0;
      dst_cnt <= '0;
    end
    else if (start)
    begin
      busy    <= 1'b1;
      phase   <= 1'b0;
      dx      <= dx_n;
      dy      <= dy_n;
      dst_cnt <= '0;
    end
    else if (busy)
    begin
      phase <= ~phase;
      dx    <= dx_n;
      dy    <= dy_n;
      if (phase)
      begin
        dst_cnt <= dst_cnt + dst_addr_t'(1);
        // stop after the final right column
        if (at_frame_end)
          busy <= 1'b0;
      end
    end
  end

  // source position, one register stage, tracks dx and dy
  always_ff @(posedge clk)
  begin
    sx_q.raw <= dx_n * step_x;
    sy_q.raw <= dy_n * step_y;
  end

  assign ix    = sx_q.split.int_part;
  assign iy    = sy_q.split.int_part;
  assign row_a = times_src_w(iy - 11'd1);
  assign row_b = row_a + src_addr_t'(src_w);
  // left column on phase 0, right column on phase 1
  assign col   = src_addr_t'(ix) + src_addr_t'(phase) - src_addr_t'(1);

  assign src_req = '{valid: busy, addr_a: row_a + col, addr_b: row_b + col};

  assign tag = '{
    phase:    phase,
    fx:       sx_q.split.frac,
    fy:       sy_q.split.frac,
    dst_addr: dst_cnt,
    last:     phase && at_frame_end
  };
  assign tag_valid = busy;

endmodule

//--- verilog/image_scaler_top.sv
`timescale 1ns/1ps

module image_scaler_top
  import scaler_pkg::*;
#(
  parameter int    src_w   = 640,
  parameter int    src_h   = 480,
  parameter int    dst_w   = 533,
  parameter int    dst_h   = 400,
  parameter step_t step_x  = 13'd4918,
  parameter step_t step_y  = 13'd4915,
  parameter int    mem_lat = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  pixel_t   src_data_a,
  input  pixel_t   src_data_b,
  output src_req_t src_req,
  output dst_wr_t  dst_wr,
  output logic     done
);

  blend_tag_t req_tag;
  logic       req_tag_vld;
  blend_tag_t dly_tag;
  logic       dly_tag_vld;

  // right column of the last pixel must stay inside the source image
  if (dst_w * step_x >= (src_w << frac_bits) || dst_h * step_y >= (src_h << frac_bits))
  begin : g_step_check
    $error("scale step reaches past the source image");
  end

  coord_gen #(
    .src_w  (src_w),
    .dst_w  (dst_w),
    .dst_h  (dst_h),
    .step_x (step_x),
    .step_y (step_y)
  ) u_coord_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .src_req   (src_req),
    .tag       (req_tag),
    .tag_valid (req_tag_vld)
  );

  tag_delay #(
    .mem_lat (mem_lat)
  ) u_tag_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .tag_in    (req_tag),
    .valid_in  (req_tag_vld),
    .tag_out   (dly_tag),
    .valid_out (dly_tag_vld)
  );

  bilinear_blend u_bilinear_blend (
    .clk        (clk),
    .rst_n      (rst_n),
    .tag        (dly_tag),
    .tag_valid  (dly_tag_vld),
    .src_data_a (src_data_a),
    .src_data_b (src_data_b),
    .dst_wr     (dst_wr),
    .done       (done)
  );

endmodule

//--- verilog/scaler_pkg.sv
package scaler_pkg;

  // Q12 coordinates
  localparam int frac_bits = 12;
  localparam logic [12:0] one_q = 13'd4096;

  typedef logic [7:0]  pixel_t;
  typedef logic [18:0] src_addr_t;
  typedef logic [18:0] dst_addr_t;
  typedef logic [9:0]  coord_t;
  typedef logic [12:0] step_t;
  typedef logic [frac_bits-1:0] frac_t;

  // coordinate times step, read whole or as integer and fraction
  typedef union packed {
    logic [22:0] raw;
    struct packed {
      logic [10:0] int_part;
      frac_t       frac;
    } split;
  } coord_q_u;

  typedef struct packed {
    logic      valid;
    src_addr_t addr_a;
    src_addr_t addr_b;
  } src_req_t;

  // travels alongside each source read
  typedef struct packed {
    logic      phase;
    frac_t     fx;
    frac_t     fy;
    dst_addr_t dst_addr;
    logic      last;
  } blend_tag_t;

  typedef struct packed {
    logic      valid;
    dst_addr_t addr;
    pixel_t    data;
  } dst_wr_t;

endpackage

//--- verilog/tag_delay.sv
`timescale 1ns/1ps

module tag_delay
  import scaler_pkg::*;
#(
  parameter int mem_lat = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  blend_tag_t tag_in,
  input  logic       valid_in,
  output blend_tag_t tag_out,
  output logic       valid_out
);

  logic [mem_lat-1:0] vld_sr;
  blend_tag_t         tag_sr [mem_lat];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      vld_sr <= '0;
    else
    begin
      vld_sr[0] <= valid_in;
      for (int i = 1; i < mem_lat; i++)
        vld_sr[i] <= vld_sr[i-1];
    end
  end

  // same depth as the memory read path
  always_ff @(posedge clk)
  begin
    tag_sr[0] <= tag_in;
    for (int i = 1; i < mem_lat; i++)
      tag_sr[i] <= tag_sr[i-1];
  end

  assign tag_out   = tag_sr[mem_lat-1];
  assign valid_out = vld_sr[mem_lat-1];

endmodule
